// File: common/periph_pkg.sv
/* shared widths, address map, register offsets, register bus structs and enums
   of the peripheral subsystem that every block imports */

package periph_pkg;

    // bus widths
    localparam int addr_w = 16;
    localparam int data_w = 32;
    localparam int strb_w = 4;

    // region field of the address sits above region_lsb
    localparam int region_lsb = 8;
    localparam int region_w = addr_w - region_lsb;
    localparam logic [region_w-1:0] gpio_region = 8'd0;
    localparam logic [region_w-1:0] timer_region = 8'd1;

    // in-region byte offsets
    localparam logic [region_lsb-1:0] gpio_out_ofs = 8'h00;
    localparam logic [region_lsb-1:0] gpio_in_ofs = 8'h04;
    localparam logic [region_lsb-1:0] tmr_count_ofs = 8'h00;
    localparam logic [region_lsb-1:0] tmr_cmp_ofs = 8'h04;
    localparam logic [region_lsb-1:0] tmr_ctrl_ofs = 8'h08;

    // axi response codes
    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef enum logic {
        op_read,
        op_write
    } reg_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_bresp,
        st_rresp
    } bridge_state_e;

    typedef struct packed {
        reg_op_e                 op;
        logic [region_lsb-1:0]   addr;
        logic [data_w-1:0]       wdata;
        logic [strb_w-1:0]       strb;
    } reg_req_t;

    typedef struct packed {
        logic [data_w-1:0]       rdata;
        logic                    ready;
    } reg_rsp_t;

    // byte lane merge for strobed register writes
    function automatic logic [data_w-1:0] strb_merge(
        input logic [data_w-1:0] old_val,
        input logic [data_w-1:0] new_val,
        input logic [strb_w-1:0] strb
    );
        logic [data_w-1:0] merged;
        merged = old_val;
        for (int i = 0; i < strb_w; i++) begin
            if (strb[i]) begin
                merged[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: verilog/axil_reg_bridge.sv
/* axi4-lite slave that accepts one transaction at a time, decodes the region
   and forwards the access to one peripheral over the internal register bus */

`timescale 1ns/1ps

module axil_reg_bridge (
    input  logic                          aclk,
    input  logic                          aresetn,
    // axi4-lite slave
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [periph_pkg::addr_w-1:0] awaddr,
    input  logic                          wvalid,
    output logic                          wready,
    input  logic [periph_pkg::data_w-1:0] wdata,
    input  logic [periph_pkg::strb_w-1:0] wstrb,
    output logic                          bvalid,
    input  logic                          bready,
    output logic [1:0]                    bresp,
    input  logic                          arvalid,
    output logic                          arready,
    input  logic [periph_pkg::addr_w-1:0] araddr,
    output logic                          rvalid,
    input  logic                          rready,
    output logic [periph_pkg::data_w-1:0] rdata,
    output logic [1:0]                    rresp,
    // register bus
    output periph_pkg::reg_req_t          req,
    output logic                          gpio_en,
    output logic                          tmr_en,
    input  periph_pkg::reg_rsp_t          gpio_rsp,
    input  periph_pkg::reg_rsp_t          tmr_rsp
);
    import periph_pkg::*;

    bridge_state_e         state;
    logic                  wr_hs;
    logic                  rd_hs;
    logic [region_w-1:0]   hs_region;
    logic                  hs_gpio;
    logic                  hs_tmr;
    reg_rsp_t              sel_rsp;
    logic [data_w-1:0]     rdata_q;
    logic [1:0]            resp_q;

    // write needs address and data in the same cycle, and beats a read
    assign wr_hs = (state == st_idle) && awvalid && wvalid;
    assign rd_hs = (state == st_idle) && arvalid && !(awvalid && wvalid);
    assign awready = wr_hs;
    assign wready = wr_hs;
    assign arready = rd_hs;

    assign hs_region = wr_hs ? awaddr[addr_w-1:region_lsb] : araddr[addr_w-1:region_lsb];
    assign hs_gpio = (hs_region == gpio_region);
    assign hs_tmr = (hs_region == timer_region);

    assign sel_rsp = gpio_en ? gpio_rsp : tmr_rsp;

    assign bvalid = (state == st_bresp);
    assign rvalid = (state == st_rresp);
    assign bresp = resp_q;
    assign rresp = resp_q;
    assign rdata = rdata_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= st_idle;
            gpio_en <= 1'b0;
            tmr_en <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (wr_hs || rd_hs) begin
                        gpio_en <= hs_gpio;
                        tmr_en <= hs_tmr;
                        // unmapped region answers right away
                        if (hs_gpio || hs_tmr) begin
                            state <= st_access;
                        end else begin
                            state <= wr_hs ? st_bresp : st_rresp;
                        end
                    end
                end
                st_access: begin
                    if (sel_rsp.ready) begin
                        gpio_en <= 1'b0;
                        tmr_en <= 1'b0;
                        state <= (req.op == op_write) ? st_bresp : st_rresp;
                    end
                end
                st_bresp: begin
                    if (bready) begin
                        state <= st_idle;
                    end
                end
                st_rresp: begin
                    if (rready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge aclk) begin
        if (wr_hs) begin
            req <= '{op: op_write, addr: awaddr[region_lsb-1:0], wdata: wdata, strb: wstrb};
            rdata_q <= '0;
            resp_q <= resp_slverr;
        end else if (rd_hs) begin
            req <= '{op: op_read, addr: araddr[region_lsb-1:0], wdata: '0, strb: '0};
            rdata_q <= '0;
            resp_q <= resp_slverr;
        end else if (state == st_access && sel_rsp.ready) begin
            resp_q <= resp_okay;
            if (req.op == op_read) begin
                rdata_q <= sel_rsp.rdata;
            end
        end
    end

    // each response channel answers only the request type that is latched
    a_one_resp: assert property (@(posedge aclk) disable iff (!aresetn)
        !(bvalid && req.op != op_write) && !(rvalid && req.op != op_read));
    a_one_en: assert property (@(posedge aclk) disable iff (!aresetn)
        !(gpio_en && tmr_en));
    // response held until the host takes it
    a_rresp_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// File: gpios/gpios.sv
/* gpio register block on the internal register bus with a byte-strobed output
   register driving the pins and a synchronized view of the input pins */

`timescale 1ns/1ps

module gpios (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          en,
    input  periph_pkg::reg_req_t          req,
    output periph_pkg::reg_rsp_t          rsp,
    input  logic [periph_pkg::data_w-1:0] gpio_in,
    output logic [periph_pkg::data_w-1:0] gpio_out
);
    import periph_pkg::*;

    logic [data_w-1:0] out_q;
    logic [data_w-1:0] sync1_q;
    logic [data_w-1:0] sync2_q;
    logic [data_w-1:0] rdata_q;
    logic              ready_q;
    logic              access;

    // act only on the first cycle of an enable
    assign access = en && !ready_q;

    assign gpio_out = out_q;
    assign rsp.rdata = rdata_q;
    assign rsp.ready = ready_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            out_q <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= access;
            if (access && req.op == op_write && req.addr == gpio_out_ofs) begin
                out_q <= strb_merge(out_q, req.wdata, req.strb);
            end
        end
    end

    // two flop input sync and read capture
    always_ff @(posedge aclk) begin
        sync1_q <= gpio_in;
        sync2_q <= sync1_q;
        if (access) begin
            case (req.addr)
                gpio_out_ofs: rdata_q <= out_q;
                gpio_in_ofs: rdata_q <= sync2_q;
                default: rdata_q <= '0;
            endcase
        end
    end

    a_ready_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        rsp.ready |=> !rsp.ready);

endmodule

// File: timer/mtimer.sv
/* machine timer on the internal register bus with a free running counter, a
   compare register, an enable and a pending bit that drives the interrupt line */

`timescale 1ns/1ps

module mtimer (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 en,
    input  periph_pkg::reg_req_t req,
    output periph_pkg::reg_rsp_t rsp,
    output logic                 irq
);
    import periph_pkg::*;

    logic [data_w-1:0] count_q;
    logic [data_w-1:0] cmp_q;
    logic              enable_q;
    logic              pending_q;
    logic [data_w-1:0] ctrl;
    logic [data_w-1:0] rdata_q;
    logic              ready_q;
    logic              access;
    logic              wr;

    assign access = en && !ready_q;
    assign wr = access && (req.op == op_write);
    assign ctrl = {{(data_w-2){1'b0}}, pending_q, enable_q};

    assign irq = pending_q;
    assign rsp.rdata = rdata_q;
    assign rsp.ready = ready_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count_q <= '0;
            cmp_q <= '0;
            enable_q <= 1'b0;
            pending_q <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= access;
            // a counter write wins over the increment
            if (wr && req.addr == tmr_count_ofs) begin
                count_q <= strb_merge(count_q, req.wdata, req.strb);
            end else if (enable_q) begin
                count_q <= count_q + 1'b1;
            end
            if (wr && req.addr == tmr_cmp_ofs) begin
                cmp_q <= strb_merge(cmp_q, req.wdata, req.strb);
            end
            if (wr && req.addr == tmr_ctrl_ofs && req.strb[0]) begin
                enable_q <= req.wdata[0];
            end
            // a new match is not lost to a clear in the same cycle
            if (enable_q && count_q == cmp_q) begin
                pending_q <= 1'b1;
            end else if (wr && req.addr == tmr_ctrl_ofs && req.strb[0] && req.wdata[1]) begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (access) begin
            case (req.addr)
                tmr_count_ofs: rdata_q <= count_q;
                tmr_cmp_ofs: rdata_q <= cmp_q;
                tmr_ctrl_ofs: rdata_q <= ctrl;
                default: rdata_q <= '0;
            endcase
        end
    end

    a_ready_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        rsp.ready |=> !rsp.ready);

endmodule

// File: verilog/periph_top.sv
/* peripheral subsystem top where the axi4-lite bridge feeds the gpio block
   and the machine timer over the shared register bus */

`timescale 1ns/1ps

module periph_top (
    input  logic                          aclk,
    input  logic                          aresetn,
    // axi4-lite slave
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [periph_pkg::addr_w-1:0] awaddr,
    input  logic                          wvalid,
    output logic                          wready,
    input  logic [periph_pkg::data_w-1:0] wdata,
    input  logic [periph_pkg::strb_w-1:0] wstrb,
    output logic                          bvalid,
    input  logic                          bready,
    output logic [1:0]                    bresp,
    input  logic                          arvalid,
    output logic                          arready,
    input  logic [periph_pkg::addr_w-1:0] araddr,
    output logic                          rvalid,
    input  logic                          rready,
    output logic [periph_pkg::data_w-1:0] rdata,
    output logic [1:0]                    rresp,
    // pins
    input  logic [periph_pkg::data_w-1:0] gpio_in,
    output logic [periph_pkg::data_w-1:0] gpio_out,
    output logic                          irq
);
    import periph_pkg::*;

    reg_req_t req;
    reg_rsp_t gpio_rsp;
    reg_rsp_t tmr_rsp;
    logic     gpio_en;
    logic     tmr_en;

    axil_reg_bridge axil_reg_bridge_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .awvalid  (awvalid),
        .awready  (awready),
        .awaddr   (awaddr),
        .wvalid   (wvalid),
        .wready   (wready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (rdata),
        .rresp    (rresp),
        .req      (req),
        .gpio_en  (gpio_en),
        .tmr_en   (tmr_en),
        .gpio_rsp (gpio_rsp),
        .tmr_rsp  (tmr_rsp)
    );

    gpios gpios_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .en       (gpio_en),
        .req      (req),
        .rsp      (gpio_rsp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    mtimer mtimer_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .en       (tmr_en),
        .req      (req),
        .rsp      (tmr_rsp),
        .irq      (irq)
    );

endmodule

// File: tests/periph_top_tb.sv
/* testbench for the peripheral subsystem where an axi4-lite master runs a table of
   register accesses against the gpio block, the timer and an unmapped region */

`timescale 1ns/1ps

module periph_top_tb;
    import periph_pkg::*;

    localparam int wait_limit = 20;
    localparam int irq_limit = 300;

    typedef enum logic [2:0] {
        act_write,
        act_read,
        act_read_min,
        act_pins,
        act_wait_irq
    } act_e;

    typedef enum logic [1:0] {
        chk_none,
        chk_pins,
        chk_irq
    } chk_e;

    // chk_irq compares irq against the ctrl pending bit held in exp
    typedef struct packed {
        act_e              act;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] strb;
        logic [data_w-1:0] exp;
        logic [1:0]        resp;
        chk_e              chk;
    } step_t;

    logic              aclk;
    logic              aresetn;
    logic              awvalid;
    logic              awready;
    logic [addr_w-1:0] awaddr;
    logic              wvalid;
    logic              wready;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              bvalid;
    logic              bready;
    logic [1:0]        bresp;
    logic              arvalid;
    logic              arready;
    logic [addr_w-1:0] araddr;
    logic              rvalid;
    logic              rready;
    logic [data_w-1:0] rdata;
    logic [1:0]        rresp;
    logic [data_w-1:0] gpio_in;
    logic [data_w-1:0] gpio_out;
    logic              irq;

    step_t       steps[$];
    int          errors;
    int          checks;
    logic [31:0] rng;

    periph_top periph_top_i (.*);

    initial aclk = 1'b0;
    always #4 aclk = ~aclk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_step(input act_e act, input logic [addr_w-1:0] addr,
                            input logic [data_w-1:0] wd, input logic [strb_w-1:0] strb,
                            input logic [data_w-1:0] exp, input logic [1:0] resp,
                            input chk_e chk);
        steps.push_back('{act, addr, wd, strb, exp, resp, chk});
    endtask

    // response channel must not move until the handshake
    task automatic check_resp_hold(input logic is_read, input logic [data_w-1:0] data,
                                   input logic [1:0] resp);
        checks++;
        if ((is_read ? rvalid : bvalid) !== 1'b1) begin
            $display("error %s got %h exp %h", is_read ? "rvalid" : "bvalid",
                     is_read ? rvalid : bvalid, 1'b1);
            errors++;
        end
        if ((is_read ? rresp : bresp) !== resp) begin
            $display("error %s got %h exp %h", is_read ? "rresp" : "bresp",
                     is_read ? rresp : bresp, resp);
            errors++;
        end
        if (is_read && rdata !== data) begin
            $display("error rdata got %h exp %h", rdata, data);
            errors++;
        end
    endtask

    // waits for the response, holds ready low 0 to 3 cycles and watches it stay put
    task automatic collect_resp(input logic is_read, output logic [data_w-1:0] data,
                                output logic [1:0] resp);
        int          n;
        int          d;
        logic        valid;
        n = 0;
        valid = 1'b0;
        data = '0;
        resp = 2'b11;
        while (!valid && n < wait_limit) begin
            @(negedge aclk);
            valid = is_read ? rvalid : bvalid;
            n++;
        end
        if (!valid) begin
            $display("timeout waiting for the %s response", is_read ? "read" : "write");
            errors++;
        end else begin
            data = rdata;
            resp = is_read ? rresp : bresp;
            rng = xorshift(rng);
            d = rng % 4;
            repeat (d) begin
                @(negedge aclk);
                check_resp_hold(is_read, data, resp);
            end
            @(posedge aclk);
            #1;
            bready = !is_read;
            rready = is_read;
            @(negedge aclk);
            check_resp_hold(is_read, data, resp);
            @(posedge aclk);
            #1;
            bready = 1'b0;
            rready = 1'b0;
        end
    endtask

    task automatic axil_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                              input logic [strb_w-1:0] strb, output logic [1:0] resp);
        int                n;
        logic              hs;
        logic [data_w-1:0] unused;
        awaddr = addr;
        wdata = data;
        wstrb = strb;
        awvalid = 1'b1;
        wvalid = 1'b1;
        n = 0;
        hs = 1'b0;
        while (!hs && n < wait_limit) begin
            @(negedge aclk);
            hs = awready && wready;
            @(posedge aclk);
            #1;
            n++;
        end
        awvalid = 1'b0;
        wvalid = 1'b0;
        resp = 2'b11;
        if (!hs) begin
            $display("timeout waiting for awready and wready at address %h", addr);
            errors++;
        end else begin
            collect_resp(1'b0, unused, resp);
        end
    endtask

    task automatic axil_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data,
                             output logic [1:0] resp);
        int   n;
        logic hs;
        araddr = addr;
        arvalid = 1'b1;
        n = 0;
        hs = 1'b0;
        while (!hs && n < wait_limit) begin
            @(negedge aclk);
            hs = arready;
            @(posedge aclk);
            #1;
            n++;
        end
        arvalid = 1'b0;
        data = '0;
        resp = 2'b11;
        if (!hs) begin
            $display("timeout waiting for arready at address %h", addr);
            errors++;
        end else begin
            collect_resp(1'b1, data, resp);
        end
    endtask

    initial begin
        step_t             s;
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        int                n;
        errors = 0;
        checks = 0;
        rng = 32'd12;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        gpio_in = '0;
        aresetn = 1'b0;

        // reset values
        add_step(act_read, 16'h0000, 0, 4'h0, 32'h0, resp_okay, chk_pins);
        add_step(act_read, 16'h0100, 0, 4'h0, 32'h0, resp_okay, chk_none);
        add_step(act_read, 16'h0108, 0, 4'h0, 32'h0, resp_okay, chk_irq);
        // gpio output bytes under strobes
        add_step(act_write, 16'h0000, 32'h1122_3344, 4'hf, 32'h1122_3344, resp_okay, chk_pins);
        add_step(act_write, 16'h0000, 32'haabb_ccdd, 4'h5, 32'h11bb_33dd, resp_okay, chk_pins);
        add_step(act_read, 16'h0000, 0, 4'h0, 32'h11bb_33dd, resp_okay, chk_pins);
        add_step(act_write, 16'h0000, 32'h5566_7788, 4'ha, 32'h55bb_77dd, resp_okay, chk_pins);
        add_step(act_read, 16'h0000, 0, 4'h0, 32'h55bb_77dd, resp_okay, chk_pins);
        // gpio input pins
        add_step(act_pins, 16'h0000, 32'hcafe_0123, 4'h0, 32'h0, resp_okay, chk_none);
        add_step(act_read, 16'h0004, 0, 4'h0, 32'hcafe_0123, resp_okay, chk_none);
        add_step(act_pins, 16'h0000, 32'h0f0f_5a5a, 4'h0, 32'h0, resp_okay, chk_none);
        add_step(act_read, 16'h0004, 0, 4'h0, 32'h0f0f_5a5a, resp_okay, chk_none);
        // timer match, pending bit and clear
        add_step(act_write, 16'h0100, 32'h10, 4'hf, 32'h0, resp_okay, chk_none);
        add_step(act_write, 16'h0104, 32'h40, 4'hf, 32'h0, resp_okay, chk_none);
        add_step(act_write, 16'h0108, 32'h1, 4'hf, 32'h0, resp_okay, chk_none);
        add_step(act_wait_irq, 16'h0000, 0, 4'h0, 32'h0, resp_okay, chk_none);
        add_step(act_read, 16'h0108, 0, 4'h0, 32'h3, resp_okay, chk_irq);
        add_step(act_read_min, 16'h0100, 0, 4'h0, 32'h40, resp_okay, chk_none);
        add_step(act_write, 16'h0108, 32'h3, 4'hf, 32'h0, resp_okay, chk_none);
        add_step(act_read, 16'h0108, 0, 4'h0, 32'h1, resp_okay, chk_irq);
        // unmapped region leaves both blocks alone
        add_step(act_write, 16'h0200, 32'hdead_beef, 4'hf, 32'h0, resp_slverr, chk_none);
        add_step(act_write, 16'h0204, 32'hdead_beef, 4'hf, 32'h0, resp_slverr, chk_none);
        add_step(act_read, 16'h0204, 0, 4'h0, 32'h0, resp_slverr, chk_none);
        add_step(act_read, 16'h0000, 0, 4'h0, 32'h55bb_77dd, resp_okay, chk_pins);
        add_step(act_read, 16'h0104, 0, 4'h0, 32'h40, resp_okay, chk_none);

        repeat (4) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(posedge aclk);
        #1;

        foreach (steps[i]) begin
            s = steps[i];
            if (s.act == act_write) begin
                axil_write(s.addr, s.wdata, s.strb, resp);
            end else if (s.act == act_read || s.act == act_read_min) begin
                axil_read(s.addr, data, resp);
                checks++;
                if (s.act == act_read && data !== s.exp) begin
                    $display("error rdata got %h exp %h at address %h", data, s.exp, s.addr);
                    errors++;
                end
                if (s.act == act_read_min && data < s.exp) begin
                    $display("error rdata got %h exp at least %h", data, s.exp);
                    errors++;
                end
            end else if (s.act == act_pins) begin
                // two sync flops plus margin before the read
                gpio_in = s.wdata;
                repeat (4) @(posedge aclk);
                #1;
            end else begin
                n = 0;
                while (!irq && n < irq_limit) begin
                    @(posedge aclk);
                    #1;
                    n++;
                end
                if (!irq) begin
                    $display("timeout waiting for irq after the timer was enabled");
                    errors++;
                end
            end
            if (s.act == act_write || s.act == act_read || s.act == act_read_min) begin
                checks++;
                if (resp !== s.resp) begin
                    $display("error resp got %h exp %h at address %h", resp, s.resp, s.addr);
                    errors++;
                end
            end
            if (s.chk == chk_pins) begin
                checks++;
                if (gpio_out !== s.exp) begin
                    $display("error gpio_out got %h exp %h", gpio_out, s.exp);
                    errors++;
                end
            end
            if (s.chk == chk_irq) begin
                checks++;
                if (irq !== s.exp[1]) begin
                    $display("error irq got %h exp %h", irq, s.exp[1]);
                    errors++;
                end
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: periph.f
common/periph_pkg.sv
verilog/axil_reg_bridge.sv
gpios/gpios.sv
timer/mtimer.sv
verilog/periph_top.sv
tests/periph_top_tb.sv

// File: Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := periph_top_tb
FLIST := periph.f

OBJ   := obj_dir
BIN   := $(OBJ)/V$(TOP)
LOG   := sim.log
SRCS  := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
